// File: logic/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // start + 8 data + parity + stop
  localparam int unsigned FRAME_BITS = 11;

  typedef enum logic
  {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } cmd_op_e;

  // host command word, bit 15 is the direction
  typedef struct packed
  {
    cmd_op_e    rw;
    logic [6:0] addr;
    logic [7:0] wdata;
  } cmd_t;

  typedef struct packed
  {
    logic [7:0] data;
    logic       parity_err;  // odd parity check failed
    logic       stop_err;    // stop bit sampled as 0
    logic       timeout;     // no start bit within the reply window
  } rd_resp_t;

  typedef enum logic [2:0]
  {
    ST_IDLE      = 3'd0,
    ST_SEND_HI   = 3'd1,
    ST_GAP       = 3'd2,
    ST_SEND_LO   = 3'd3,
    ST_WAIT_RESP = 3'd4,
    ST_RECV      = 3'd5,
    ST_DONE      = 3'd6
  } ctrl_state_e;

endpackage

// File: logic/baud_timer.sv
`timescale 1ns/1ps

module baud_timer #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tick_run,
  output logic       bit_tick,
  input  logic       load,
  input  logic [7:0] load_bits,
  output logic       expired
);

  localparam int DW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [DW-1:0] DIV_LAST = DW'(CLKS_PER_BIT - 1);

  logic [DW-1:0] div_cnt;
  logic [7:0]    bits_left;

  assign bit_tick = tick_run && (div_cnt == DIV_LAST);
  assign expired  = bit_tick && (bits_left == 8'd1);  // last counted bit period

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      div_cnt <= '0;
    else if (!tick_run || bit_tick)
      div_cnt <= '0;  // phase restarts whenever the divider is stopped
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bits_left <= 8'd0;
    else if (!tick_run)
      bits_left <= 8'd0;
    else if (load)
      bits_left <= load_bits;  // a tick in the load cycle is not counted
    else if (bit_tick && (bits_left != 8'd0))
      bits_left <= bits_left - 8'd1;
  end

endmodule

// File: logic/uart_tx_shifter.sv
`timescale 1ns/1ps

module uart_tx_shifter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       bit_tick,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_done
);
  import uart_cmd_pkg::*;

  localparam logic [3:0] LAST_BIT = 4'(FRAME_BITS - 1);

  logic [FRAME_BITS-1:0] shreg;
  logic [3:0]            bit_cnt;
  logic                  busy;
  logic                  parity;

  assign parity  = ~^tx_byte;  // makes data plus parity odd
  assign tx      = shreg[0];
  assign tx_done = busy && bit_tick && (bit_cnt == LAST_BIT);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shreg   <= '1;  // line idles high
      bit_cnt <= 4'd0;
      busy    <= 1'b0;
    end
    else if (tx_start)
    begin
      shreg   <= {1'b1, parity, tx_byte, 1'b0};
      bit_cnt <= 4'd0;
      busy    <= 1'b1;
    end
    else if (busy && bit_tick)
    begin
      shreg <= {1'b1, shreg[FRAME_BITS-1:1]};  // refill with idle level
      if (bit_cnt == LAST_BIT)
      begin
        busy    <= 1'b0;
        bit_cnt <= 4'd0;
      end
      else
        bit_cnt <= bit_cnt + 4'd1;
    end
  end

endmodule

// File: logic/uart_rx_sampler.sv
`timescale 1ns/1ps

module uart_rx_sampler #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rx,
  input  logic                   rx_arm,
  output logic                   rx_busy,
  output logic                   rx_done,
  output uart_cmd_pkg::rd_resp_t rx_result
);
  import uart_cmd_pkg::*;

  localparam int PW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [PW-1:0] PH_LAST = PW'(CLKS_PER_BIT - 1);
  localparam logic [PW-1:0] PH_MID  = PW'(CLKS_PER_BIT / 2);
  localparam logic [PW-1:0] PH_ONE  = PW'(1);
  localparam logic [3:0] PAR_IDX    = 4'(FRAME_BITS - 2);
  localparam logic [3:0] STOP_IDX   = 4'(FRAME_BITS - 1);

  logic          rx_s1;
  logic          rx_s2;
  logic          rx_prev;
  logic [PW-1:0] phase;
  logic [3:0]    bit_idx;
  logic [7:0]    data_sh;
  logic          par_acc;
  logic          start_seen;
  logic          mid;

  assign start_seen = rx_arm && !rx_busy && rx_prev && !rx_s2;
  assign mid        = rx_busy && (phase == PH_MID);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;  // edge detect only
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_busy <= 1'b0;
      rx_done <= 1'b0;
      phase   <= '0;
      bit_idx <= 4'd0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (!rx_arm)
        rx_busy <= 1'b0;
      else if (start_seen)
      begin
        rx_busy <= 1'b1;
        phase   <= PH_ONE;  // edge cycle counts as phase 0
        bit_idx <= 4'd0;
      end
      else if (rx_busy)
      begin
        phase <= (phase == PH_LAST) ? '0 : phase + PH_ONE;
        if (mid)
        begin
          bit_idx <= bit_idx + 4'd1;
          if ((bit_idx == 4'd0) && rx_s2)
            rx_busy <= 1'b0;  // glitch, not a start bit
          else if (bit_idx == STOP_IDX)
          begin
            rx_busy <= 1'b0;
            rx_done <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_seen)
      par_acc <= 1'b0;
    else if (mid)
    begin
      if ((bit_idx != 4'd0) && (bit_idx < PAR_IDX))
        data_sh <= {rx_s2, data_sh[7:1]};  // lsb arrives first
      if ((bit_idx != 4'd0) && (bit_idx <= PAR_IDX))
        par_acc <= par_acc ^ rx_s2;
      if (bit_idx == STOP_IDX)
      begin
        rx_result.data       <= data_sh;
        rx_result.parity_err <= ~par_acc;
        rx_result.stop_err   <= ~rx_s2;
        rx_result.timeout    <= 1'b0;
      end
    end
  end

endmodule

// File: logic/uart_cmd_ctrl.sv
`timescale 1ns/1ps

module uart_cmd_ctrl #(
  parameter int GAP_BITS          = 4,
  parameter int RESP_TIMEOUT_BITS = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_vld,
  input  uart_cmd_pkg::cmd_t     cmd,
  output logic                   cmd_rdy,
  output logic                   tick_run,
  output logic                   load,
  output logic [7:0]             load_bits,
  input  logic                   expired,
  output logic                   tx_start,
  output logic [7:0]             tx_byte,
  input  logic                   tx_done,
  output logic                   rx_arm,
  input  logic                   rx_busy,
  input  logic                   rx_done,
  input  uart_cmd_pkg::rd_resp_t rx_result,
  output logic                   read_rdy,
  output uart_cmd_pkg::rd_resp_t read_resp
);
  import uart_cmd_pkg::*;

  localparam logic [7:0] GAP_LOAD  = 8'(GAP_BITS);
  localparam logic [7:0] RESP_LOAD = 8'(RESP_TIMEOUT_BITS);
  localparam rd_resp_t TIMEOUT_RESP = '{
    data:       8'h00,
    parity_err: 1'b0,
    stop_err:   1'b0,
    timeout:    1'b1
  };

  ctrl_state_e state;
  ctrl_state_e state_nx;
  cmd_t        cmd_q;
  cmd_op_e     op;
  logic        is_write;
  logic        accept;
  logic        start_hi;

  assign accept   = cmd_vld && cmd_rdy;
  assign op       = cmd_q.rw;
  assign is_write = (op == CMD_WRITE);

  assign cmd_rdy  = (state == ST_IDLE);
  // divider starts with the start bit so ticks line up with frame bits
  assign tick_run = ((state == ST_SEND_HI) && !start_hi) || (state == ST_GAP) ||
                    (state == ST_SEND_LO) || (state == ST_WAIT_RESP);
  assign load      = (state == ST_SEND_HI) && tx_done;
  assign load_bits = is_write ? GAP_LOAD : RESP_LOAD;
  assign tx_start  = start_hi || ((state == ST_GAP) && expired);
  assign tx_byte   = (state == ST_GAP) ? cmd_q.wdata : {cmd_q.rw, cmd_q.addr};
  assign rx_arm    = (state == ST_WAIT_RESP) || (state == ST_RECV);

  always_comb
  begin
    state_nx = state;
    case (state)
      ST_IDLE:
        if (accept)
          state_nx = ST_SEND_HI;
      ST_SEND_HI:
        if (tx_done)
          state_nx = is_write ? ST_GAP : ST_WAIT_RESP;
      ST_GAP:
        if (expired)
          state_nx = ST_SEND_LO;
      ST_SEND_LO:
        if (tx_done)
          state_nx = ST_DONE;
      ST_WAIT_RESP:
        if (rx_busy)
          state_nx = ST_RECV;  // reply frame has begun
        else if (expired)
          state_nx = ST_DONE;
      ST_RECV:
        if (rx_done || !rx_busy)
          state_nx = ST_DONE;
      ST_DONE:
        if (is_write || read_rdy)
          state_nx = ST_IDLE;  // reads stay one more cycle for read_rdy
      default:
        state_nx = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      start_hi <= 1'b0;
      read_rdy <= 1'b0;
    end
    else
    begin
      state    <= state_nx;
      start_hi <= accept;
      read_rdy <= (state == ST_DONE) && !is_write && !read_rdy;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd;
    if ((state == ST_WAIT_RESP) && !rx_busy && expired)
      read_resp <= TIMEOUT_RESP;
    else if ((state == ST_RECV) && rx_done)
    begin
      read_resp <= '{
        data:       rx_result.data,
        parity_err: rx_result.parity_err,
        stop_err:   rx_result.stop_err,
        timeout:    1'b0
      };
    end
    else if ((state == ST_RECV) && !rx_busy)
      read_resp <= TIMEOUT_RESP;  // start bit was rejected
  end

endmodule

// File: logic/uart_cmd_bridge.sv
`timescale 1ns/1ps

module uart_cmd_bridge #(
  parameter int CLKS_PER_BIT      = 434,
  parameter int GAP_BITS          = 4,
  parameter int RESP_TIMEOUT_BITS = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_vld,
  input  uart_cmd_pkg::cmd_t     cmd,
  output logic                   cmd_rdy,
  input  logic                   rx,
  output logic                   tx,
  output logic                   read_rdy,
  output uart_cmd_pkg::rd_resp_t read_resp
);
  import uart_cmd_pkg::*;

  logic       tick_run;
  logic       bit_tick;
  logic       load;
  logic [7:0] load_bits;
  logic       expired;
  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_done;
  logic       rx_arm;
  logic       rx_busy;
  logic       rx_done;
  rd_resp_t   rx_result;

  uart_cmd_ctrl #(
    .GAP_BITS          (GAP_BITS),
    .RESP_TIMEOUT_BITS (RESP_TIMEOUT_BITS)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .cmd       (cmd),
    .cmd_rdy   (cmd_rdy),
    .tick_run  (tick_run),
    .load      (load),
    .load_bits (load_bits),
    .expired   (expired),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_arm    (rx_arm),
    .rx_busy   (rx_busy),
    .rx_done   (rx_done),
    .rx_result (rx_result),
    .read_rdy  (read_rdy),
    .read_resp (read_resp)
  );

  baud_timer #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_timer (
    .clk       (clk),
    .rst_n     (rst_n),
    .tick_run  (tick_run),
    .bit_tick  (bit_tick),
    .load      (load),
    .load_bits (load_bits),
    .expired   (expired)
  );

  uart_tx_shifter u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .bit_tick (bit_tick),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_sampler #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_arm    (rx_arm),
    .rx_busy   (rx_busy),
    .rx_done   (rx_done),
    .rx_result (rx_result)
  );

endmodule

// File: testbench/uart_cmd_properties.sv
`timescale 1ns/1ps

module uart_cmd_properties (
  input logic                      clk,
  input logic                      rst_n,
  input uart_cmd_pkg::ctrl_state_e state,
  input logic                      cmd_vld,
  input logic                      is_write,
  input logic                      cmd_rdy,
  input logic                      read_rdy,
  input logic                      tx_start,
  input logic                      tx_done
);
  import uart_cmd_pkg::*;

  logic frame_busy;
  logic cmd_busy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      frame_busy <= 1'b0;
    else if (tx_start)
      frame_busy <= 1'b1;
    else if (tx_done)
      frame_busy <= 1'b0;  // stop bit finished
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cmd_busy <= 1'b0;
    else if (cmd_vld && cmd_rdy)
      cmd_busy <= 1'b1;
    else if (read_rdy || ((state == ST_DONE) && is_write))
      cmd_busy <= 1'b0;  // command retired
  end

  rdy_only_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> !cmd_busy) else $error("cmd_rdy high while a command is in progress");

  read_rdy_single: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> cmd_busy) else $error("read_rdy repeated or without a pending command");

  start_when_free: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !frame_busy) else $error("tx_start while a frame is still running");

  start_single: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |=> !tx_start) else $error("tx_start held longer than one cycle");

endmodule

bind uart_cmd_ctrl uart_cmd_properties u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .state    (state),
  .cmd_vld  (cmd_vld),
  .is_write (is_write),
  .cmd_rdy  (cmd_rdy),
  .read_rdy (read_rdy),
  .tx_start (tx_start),
  .tx_done  (tx_done)
);

// File: testbench/tb_uart_cmd_bridge.sv
`timescale 1ns/1ps

module tb_uart_cmd_bridge;
  import uart_cmd_pkg::*;

  localparam int CPB       = 8;
  localparam int GAP       = 4;
  localparam int RESP_TO   = 32;
  localparam int LIMIT     = 4000;  // cycles allowed for any single wait
  localparam int STOP_REST = CPB - CPB / 2;  // stop bit still on tx after its mid-bit sample

  logic     clk;
  logic     rst_n;
  logic     cmd_vld;
  cmd_t     cmd;
  logic     cmd_rdy;
  logic     rx;
  logic     tx;
  logic     read_rdy;
  rd_resp_t read_resp;
  integer   seed = 32'h9369;
  int       rdy_pulses = 0;
  int       accepts = 0;

  uart_cmd_bridge #(
    .CLKS_PER_BIT      (CPB),
    .GAP_BITS          (GAP),
    .RESP_TIMEOUT_BITS (RESP_TO)
  ) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .cmd       (cmd),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_resp (read_resp)
  );

  always #10 clk = ~clk;

  always @(negedge clk)  // dut outputs are settled here
  begin
    if (read_rdy)
      rdy_pulses <= rdy_pulses + 1;
    if (cmd_vld && cmd_rdy)
      accepts <= accepts + 1;  // the next rising edge takes the command
  end

  function automatic logic odd_parity_bit(input logic [7:0] b);
    return ($countones(b) % 2 == 0);  // an even count of data ones needs a parity one
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
      stop_on_error($sformatf("FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic wait_ready();
    int n = 0;
    while (cmd_rdy !== 1'b1)
    begin
      @(negedge clk);
      n++;
      assert (n < LIMIT) else stop_on_error("timeout waiting for cmd_rdy to return");
    end
  endtask

  task automatic send_cmd(input cmd_t c, input logic hold);
    int n = 0;
    @(posedge clk);
    #1;
    cmd     = c;
    cmd_vld = 1'b1;
    do
    begin
      @(negedge clk);
      n++;
      assert (n < LIMIT) else stop_on_error("timeout waiting for the command to be accepted");
    end
    while (cmd_rdy !== 1'b1);
    @(posedge clk);  // acceptance edge
    #1;
    cmd_vld = hold;
  endtask

  task automatic capture_frame(output logic [7:0] data);
    logic par;
    int   n = 0;
    while (tx !== 1'b0)
    begin
      @(negedge clk);
      n++;
      assert (n < LIMIT) else stop_on_error("timeout waiting for a start bit on tx");
    end
    repeat (CPB / 2) @(negedge clk);  // move to mid-bit
    assert (tx === 1'b0) else stop_on_error("start bit on tx did not last to mid-bit");
    for (int i = 0; i < 8; i++)
    begin
      repeat (CPB) @(negedge clk);
      data[i] = tx;
    end
    repeat (CPB) @(negedge clk);
    par = tx;
    repeat (CPB) @(negedge clk);
    check_value("tx parity bit", 32'(par), 32'(odd_parity_bit(data)));
    check_value("tx stop bit", 32'(tx), 32'(1'b1));
  endtask

  task automatic measure_idle(output int cycles);
    cycles = 0;
    while (tx === 1'b1)
    begin
      @(negedge clk);
      cycles++;
      assert (cycles < LIMIT) else stop_on_error("tx never started the second frame");
    end
  endtask

  task automatic send_reply(input logic [7:0] data, input logic par, input logic stop);
    logic [FRAME_BITS-1:0] frame;
    frame = {stop, par, data, 1'b0};
    @(posedge clk);
    #1;
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      rx = frame[i];
      repeat (CPB) @(posedge clk);
      #1;
    end
    rx = 1'b1;
  endtask

  task automatic wait_read(output rd_resp_t resp, output int cycles);
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
      assert (cycles < LIMIT) else stop_on_error("timeout waiting for read_rdy");
    end
    while (read_rdy !== 1'b1);
    resp = read_resp;
  endtask

  task automatic test_write(input logic hold);
    cmd_t       c;
    logic [7:0] hi;
    logic [7:0] lo;
    int         idle;
    int         pulses;
    int         acc;
    c.rw    = CMD_WRITE;
    c.addr  = 7'($random(seed));
    c.wdata = 8'($random(seed));
    pulses  = rdy_pulses;
    acc     = accepts;
    send_cmd(c, hold);
    capture_frame(hi);
    check_value("tx high byte", 32'(hi), 32'({1'b1, c.addr}));
    assert (cmd_rdy === 1'b0) else stop_on_error("cmd_rdy went high during a write");
    measure_idle(idle);
    assert (idle >= GAP * CPB + STOP_REST)
    else
      stop_on_error("tx gap between write frames is too short");
    capture_frame(lo);
    check_value("tx data byte", 32'(lo), 32'(c.wdata));
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
    wait_ready();
    check_value("read_rdy pulse count", rdy_pulses - pulses, 0);
    check_value("accepted commands", accepts - acc, 1);
    repeat (2 * FRAME_BITS * CPB)
    begin
      @(negedge clk);
      assert (tx === 1'b1) else stop_on_error("tx sent an extra frame after the write");
    end
  endtask

  // kind 0 clean reply, 1 bad parity, 2 stop bit low, 3 no reply at all
  task automatic test_read(input int kind);
    cmd_t       c;
    logic [7:0] hi;
    logic [7:0] reply;
    rd_resp_t   resp;
    rd_resp_t   exp;
    int         cycles;
    int         pulses;
    c.rw    = CMD_READ;
    c.addr  = 7'($random(seed));
    c.wdata = 8'($random(seed));
    reply   = 8'($random(seed));
    pulses  = rdy_pulses;
    send_cmd(c, 1'b0);
    capture_frame(hi);
    check_value("tx high byte", 32'(hi), 32'({1'b0, c.addr}));
    if (kind == 3)
      wait_read(resp, cycles);
    else
      fork
        begin
          repeat (2 * CPB) @(negedge clk);  // receiver arms after the stop bit
          send_reply(reply, odd_parity_bit(reply) ^ (kind == 1), kind != 2);
        end
        wait_read(resp, cycles);
      join
    exp.data       = (kind == 3) ? 8'h00 : reply;
    exp.parity_err = (kind == 1);
    exp.stop_err   = (kind == 2);
    exp.timeout    = (kind == 3);
    check_value("read_resp", 32'(resp), 32'(exp));
    if (kind == 3)
      assert (cycles >= RESP_TO * CPB + STOP_REST)
      else
        stop_on_error("read timed out too early");
    wait_ready();
    check_value("read_rdy pulse count", rdy_pulses - pulses, 1);
  endtask

  initial
  begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd     = '0;
    rx      = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("tx", 32'(tx), 32'(1'b1));
    check_value("cmd_rdy", 32'(cmd_rdy), 32'(1'b1));
    check_value("read_rdy", 32'(read_rdy), 32'(1'b0));
    test_write(1'b0);
    test_read(0);
    test_read(1);
    test_read(2);
    test_read(3);
    test_write(1'b1);  // cmd_vld held through the whole command
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: uart_cmd_bridge.f
logic/uart_cmd_pkg.sv
logic/baud_timer.sv
logic/uart_tx_shifter.sv
logic/uart_rx_sampler.sv
logic/uart_cmd_ctrl.sv
logic/uart_cmd_bridge.sv
testbench/uart_cmd_properties.sv
testbench/tb_uart_cmd_bridge.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module tb_uart_cmd_bridge -f uart_cmd_bridge.f &&
./obj_dir/Vtb_uart_cmd_bridge > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1
